// ==== src/kcpu_pkg.sv ====
////////////////////////////////////////////////////////////
// shared types and constants for the kcpu memory side
// every block reaches these through kcpu_pkg:: names
////////////////////////////////////////////////////////////

package kcpu_pkg;

    typedef logic [15:0] addr_t;   // cpu address space is 64K
    typedef logic [7:0]  byte_t;   // ram is byte wide

    // commands accepted by the cpu memory controller
    typedef enum logic [2:0] {
        op_fetch,   // single opcode byte at pc
        opd_fetch,  // 16-bit operand at pc
        load8,
        load16,
        store8,
        store16,
        vec_fetch   // 16-bit read at an interrupt vector
    } mem_cmd_e;

    typedef enum logic [1:0] {sel_x, sel_y, sel_idx, sel_stack} addr_sel_e;

    typedef struct packed {
        byte_t opcode;    // upper byte
        byte_t postbyte;  // lower byte, zero on op_fetch
    } op_word_t;

    // fetch result, read as a plain word or as opcode plus postbyte
    typedef union packed {
        logic [15:0] word;
        op_word_t    op;
    } fetch_word_u;

    localparam int REQ_CREDITS = 2;  // also the arbiter queue depth

    // interrupt vector locations, high byte first in memory
    localparam addr_t VEC_FIRQ = 16'hFFF6;
    localparam addr_t VEC_IRQ  = 16'hFFF8;
    localparam addr_t VEC_NMI  = 16'hFFFC;
    localparam addr_t VEC_RST  = 16'hFFFE;

endpackage

// ==== src/kcpu_mem_if.sv ====
////////////////////////////////////////////////////////////
// byte request channel between one requester and the
// arbiter, with credit return and in-order read data
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

interface kcpu_mem_if (
    input logic clk,
    input logic rst
);
    logic            req;     // one cycle per byte, spends a credit
    kcpu_pkg::addr_t addr;
    logic            we;
    kcpu_pkg::byte_t wdata;
    logic            credit;  // pulse, one credit back
    logic            rvalid;  // read byte, in request order
    kcpu_pkg::byte_t rdata;

    modport requester (input credit, rvalid, rdata, output req, addr, we, wdata);
    modport arbiter   (input req, addr, we, wdata, output credit, rvalid, rdata);

    // nothing may be queued while the system is held in reset
    a_no_req_in_rst: assert property (@(posedge clk) rst |-> !req);

endinterface

// ==== src/kcpu_ram.sv ====
////////////////////////////////////////////////////////////
// 64K x 8 synchronous ram, read data one cycle after
// ram_en, driven only by the arbiter
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module kcpu_ram (
    input  logic             clk,
    input  logic             ram_en,
    input  logic             ram_we,
    input  kcpu_pkg::addr_t  ram_addr,
    input  kcpu_pkg::byte_t  ram_wdata,
    output kcpu_pkg::byte_t  ram_rdata
);

    kcpu_pkg::byte_t mem [65536];

    always_ff @(posedge clk) begin
        if (ram_en) begin
            if (ram_we) mem[ram_addr] <= ram_wdata;
            else ram_rdata <= mem[ram_addr];   // registered read
        end
    end

endmodule

// ==== src/kcpu_mem_arb.sv ====
////////////////////////////////////////////////////////////
// round-robin arbiter for the cpu and dma ports
// each port owns a small request queue, a pop sends one
// credit back, read bytes return to their owner two
// cycles after the pop
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module kcpu_mem_arb (
    input  logic             clk,
    input  logic             rst,
    kcpu_mem_if.arbiter      cpu,
    kcpu_mem_if.arbiter      dma,
    output logic             ram_en,
    output logic             ram_we,
    output kcpu_pkg::addr_t  ram_addr,
    output kcpu_pkg::byte_t  ram_wdata,
    input  kcpu_pkg::byte_t  ram_rdata
);

    typedef struct packed {
        logic            we;
        kcpu_pkg::addr_t addr;
        kcpu_pkg::byte_t wdata;
    } entry_t;

    entry_t           queue [2][kcpu_pkg::REQ_CREDITS];
    entry_t           in_e [2];
    entry_t           head;
    logic [1:0]       push, nempty, grant;
    logic [1:0]       credit_q, s1_rd, s2_rd, rvalid_q;  // one bit per port
    logic [1:0]       cnt [2];
    logic             wr_ptr [2];
    logic             rd_ptr [2];
    logic             last;       // port granted most recently
    logic             sel;
    kcpu_pkg::byte_t  rdata_q;

    // port 0 is the cpu, port 1 the dma engine
    assign push  = {dma.req, cpu.req};
    assign in_e[0] = '{we: cpu.we, addr: cpu.addr, wdata: cpu.wdata};
    assign in_e[1] = '{we: dma.we, addr: dma.addr, wdata: dma.wdata};
    assign nempty = {cnt[1] != 2'd0, cnt[0] != 2'd0};

    always_comb begin
        if (nempty == 2'b11) grant = last ? 2'b01 : 2'b10;  // alternate under contention
        else grant = nempty;
    end

    assign sel  = grant[1];
    assign head = queue[sel][rd_ptr[sel]];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int p = 0; p < 2; p++) begin
                cnt[p]    <= 2'd0;
                wr_ptr[p] <= 1'b0;
                rd_ptr[p] <= 1'b0;
            end
            last     <= 1'b0;
            credit_q <= 2'b00;
            ram_en   <= 1'b0;
            ram_we   <= 1'b0;
            s1_rd    <= 2'b00;
            s2_rd    <= 2'b00;
            rvalid_q <= 2'b00;
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (push[p]) wr_ptr[p] <= !wr_ptr[p];
                if (grant[p]) rd_ptr[p] <= !rd_ptr[p];
                cnt[p] <= cnt[p] + 2'(push[p]) - 2'(grant[p]);
            end
            if (grant != 2'b00) last <= sel;
            credit_q <= grant;                          // credit back on the pop
            ram_en   <= grant != 2'b00;
            ram_we   <= (grant != 2'b00) && head.we;
            s1_rd    <= grant & {2{!head.we}};          // owner of a read, ram stage
            s2_rd    <= s1_rd;                          // output stage
            rvalid_q <= s2_rd;
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (push[p]) queue[p][wr_ptr[p]] <= in_e[p];
        end
        ram_addr  <= head.addr;
        ram_wdata <= head.wdata;
        rdata_q   <= ram_rdata;
    end

    assign cpu.credit = credit_q[0];
    assign dma.credit = credit_q[1];
    assign cpu.rvalid = rvalid_q[0];
    assign dma.rvalid = rvalid_q[1];
    assign cpu.rdata  = rdata_q;
    assign dma.rdata  = rdata_q;

    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        !(push[0] && cnt[0] == 2'(kcpu_pkg::REQ_CREDITS)) &&
        !(push[1] && cnt[1] == 2'(kcpu_pkg::REQ_CREDITS)));

endmodule

// ==== src/kcpu_memctrl.sv ====
////////////////////////////////////////////////////////////
// cpu memory controller
// picks the access address from pc, x, y, the indexed
// address, the stack pointer or an interrupt vector, then
// runs one or two byte accesses, high byte first
// pulse cmd_start while busy is low, wait for done
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module kcpu_memctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  kcpu_pkg::addr_t        pc,
    input  kcpu_pkg::addr_t        regs_x,
    input  kcpu_pkg::addr_t        regs_y,
    input  kcpu_pkg::addr_t        idx_addr,
    input  kcpu_pkg::addr_t        stack_ptr,
    input  logic [15:0]            store_data,
    input  logic                   cmd_start,
    input  kcpu_pkg::mem_cmd_e     cmd,
    input  kcpu_pkg::addr_sel_e    sel,
    input  logic [3:0]             intvec,      // one-hot vector select
    output logic                   busy,
    output logic                   done,
    output logic                   is_op,
    output kcpu_pkg::fetch_word_u  result,
    kcpu_mem_if.requester          mem
);

    logic                 go;
    logic                 start_wr, start_wide;
    kcpu_pkg::addr_t      sel_addr, start_addr;
    logic [1:0]           credits;            // 0..REQ_CREDITS
    logic [1:0]           issued, rcvd;       // bytes requested / returned
    logic                 need_more, last_iss, last_rcv;
    kcpu_pkg::mem_cmd_e   cmd_q;
    kcpu_pkg::addr_t      base_q;
    logic                 wide_q, wr_q;
    logic [15:0]          wdata_q;            // first byte always in [15:8]

    assign go = cmd_start && !busy;

    always_comb begin
        start_wr   = (cmd == kcpu_pkg::store8) || (cmd == kcpu_pkg::store16);
        start_wide = !((cmd == kcpu_pkg::op_fetch) || (cmd == kcpu_pkg::load8) ||
                       (cmd == kcpu_pkg::store8));
        case (sel)
            kcpu_pkg::sel_x:   sel_addr = regs_x;
            kcpu_pkg::sel_y:   sel_addr = regs_y;
            kcpu_pkg::sel_idx: sel_addr = idx_addr;
            default:           sel_addr = start_wr ? stack_ptr - 16'd1 : stack_ptr; // push/pull
        endcase
        case (cmd)
            kcpu_pkg::op_fetch, kcpu_pkg::opd_fetch: start_addr = pc;
            kcpu_pkg::vec_fetch: begin
                case (intvec)
                    4'b0001: start_addr = kcpu_pkg::VEC_IRQ;
                    4'b0010: start_addr = kcpu_pkg::VEC_FIRQ;
                    4'b0100: start_addr = kcpu_pkg::VEC_NMI;
                    default: start_addr = kcpu_pkg::VEC_RST;
                endcase
            end
            default: start_addr = sel_addr;
        endcase
    end

    // second byte only for 16-bit commands
    assign need_more = issued <= {1'b0, wide_q};
    assign last_iss  = issued == {1'b0, wide_q};
    assign last_rcv  = rcvd == {1'b0, wide_q};

    assign mem.req   = busy && need_more && (credits != 2'd0);
    assign mem.addr  = base_q + kcpu_pkg::addr_t'(issued);
    assign mem.we    = wr_q;
    assign mem.wdata = (issued == 2'd0) ? wdata_q[15:8] : wdata_q[7:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            is_op   <= 1'b0;
            credits <= 2'(kcpu_pkg::REQ_CREDITS);
            issued  <= 2'd0;
            rcvd    <= 2'd0;
        end else begin
            done    <= 1'b0;
            is_op   <= 1'b0;   // only high alongside done
            credits <= credits - 2'(mem.req) + 2'(mem.credit);
            if (go) begin
                busy   <= 1'b1;
                issued <= 2'd0;
                rcvd   <= 2'd0;
            end else if (busy) begin
                if (mem.req) issued <= issued + 2'd1;
                if (mem.rvalid) rcvd <= rcvd + 2'd1;
                // writes end at the last request, reads at the last byte back
                if (wr_q ? (mem.req && last_iss) : (mem.rvalid && last_rcv)) begin
                    busy  <= 1'b0;
                    done  <= 1'b1;
                    is_op <= cmd_q == kcpu_pkg::op_fetch;
                end
            end
        end
    end

    // command payload and result word
    always_ff @(posedge clk) begin
        if (go) begin
            cmd_q   <= cmd;
            base_q  <= start_addr;
            wide_q  <= start_wide;
            wr_q    <= start_wr;
            wdata_q <= start_wide ? store_data : {store_data[7:0], 8'h00};
        end
        if (busy && mem.rvalid) begin
            if (cmd_q == kcpu_pkg::op_fetch) begin
                result.op.opcode   <= mem.rdata;
                result.op.postbyte <= 8'h00;
            end else if (!wide_q) begin
                result.word <= {8'h00, mem.rdata};     // load8 lands low
            end else if (rcvd == 2'd0) begin
                result.word[15:8] <= mem.rdata;        // high byte first
            end else begin
                result.word[7:0] <= mem.rdata;
            end
        end
    end

    a_credit_max: assert property (@(posedge clk) disable iff (rst)
        credits <= 2'(kcpu_pkg::REQ_CREDITS));

    a_vec_onehot: assert property (@(posedge clk) disable iff (rst)
        (go && cmd == kcpu_pkg::vec_fetch) |-> $onehot(intvec));

endmodule

// ==== src/kcpu_dma.sv ====
////////////////////////////////////////////////////////////
// block copy engine, moves dma_len bytes from dma_src to
// dma_dst through its own arbiter port
// pulse dma_start while dma_busy is low, wait for dma_done
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module kcpu_dma (
    input  logic             clk,
    input  logic             rst,
    input  logic             dma_start,
    input  kcpu_pkg::addr_t  dma_src,
    input  kcpu_pkg::addr_t  dma_dst,
    input  logic [7:0]       dma_len,
    output logic             dma_busy,
    output logic             dma_done,
    kcpu_mem_if.requester    mem
);

    logic [1:0]       credits;
    logic [7:0]       len_q;
    logic [7:0]       rd_cnt, rcv_cnt, wr_cnt;  // reads issued, bytes back, writes issued
    logic [7:0]       in_flight;
    kcpu_pkg::addr_t  src_q, dst_q;
    kcpu_pkg::byte_t  hold [kcpu_pkg::REQ_CREDITS];  // bytes waiting for a write credit
    logic             have_byte, req_wr, req_rd;

    assign have_byte = rcv_cnt != wr_cnt;
    assign in_flight = rd_cnt - wr_cnt;          // reads out plus held bytes
    assign req_wr    = dma_busy && have_byte && (credits != 2'd0);   // writes go first
    assign req_rd    = dma_busy && !have_byte && (credits != 2'd0) && (rd_cnt != len_q) &&
                       (in_flight < 8'(kcpu_pkg::REQ_CREDITS));

    assign mem.req   = req_wr || req_rd;
    assign mem.we    = have_byte;
    assign mem.addr  = have_byte ? dst_q + kcpu_pkg::addr_t'(wr_cnt)
                                 : src_q + kcpu_pkg::addr_t'(rd_cnt);
    assign mem.wdata = hold[wr_cnt[0]];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dma_busy <= 1'b0;
            dma_done <= 1'b0;
            credits  <= 2'(kcpu_pkg::REQ_CREDITS);
            rd_cnt   <= 8'd0;
            rcv_cnt  <= 8'd0;
            wr_cnt   <= 8'd0;
        end else begin
            dma_done <= 1'b0;
            credits  <= credits - 2'(mem.req) + 2'(mem.credit);
            if (dma_start && !dma_busy) begin
                dma_busy <= dma_len != 8'd0;
                dma_done <= dma_len == 8'd0;     // empty copy ends at once
                rd_cnt   <= 8'd0;
                rcv_cnt  <= 8'd0;
                wr_cnt   <= 8'd0;
            end else if (dma_busy) begin
                if (req_rd) rd_cnt <= rd_cnt + 8'd1;
                if (mem.rvalid) rcv_cnt <= rcv_cnt + 8'd1;
                if (req_wr) begin
                    wr_cnt <= wr_cnt + 8'd1;
                    if (wr_cnt == len_q - 8'd1) begin   // last write issued
                        dma_busy <= 1'b0;
                        dma_done <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dma_start && !dma_busy) begin
            src_q <= dma_src;
            dst_q <= dma_dst;
            len_q <= dma_len;
        end
        if (mem.rvalid) hold[rcv_cnt[0]] <= mem.rdata;
    end

    // a request on an empty count or a stray credit pushes the count out of range
    a_req_credit: assert property (@(posedge clk) disable iff (rst)
        credits <= 2'(kcpu_pkg::REQ_CREDITS));

endmodule

// ==== src/kcpu_memsys.sv ====
////////////////////////////////////////////////////////////
// memory subsystem top level
// cpu controller and dma engine share one byte ram
// through the round-robin arbiter, all pins are plain
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module kcpu_memsys (
    input  logic                   clk,
    input  logic                   rst,
    input  kcpu_pkg::addr_t        pc,
    input  kcpu_pkg::addr_t        regs_x,
    input  kcpu_pkg::addr_t        regs_y,
    input  kcpu_pkg::addr_t        idx_addr,
    input  kcpu_pkg::addr_t        stack_ptr,
    input  logic [15:0]            store_data,
    input  logic                   cmd_start,
    input  kcpu_pkg::mem_cmd_e     cmd,
    input  kcpu_pkg::addr_sel_e    sel,
    input  logic [3:0]             intvec,
    output logic                   busy,
    output logic                   done,
    output kcpu_pkg::fetch_word_u  result,
    output logic                   is_op,
    input  logic                   dma_start,
    input  kcpu_pkg::addr_t        dma_src,
    input  kcpu_pkg::addr_t        dma_dst,
    input  logic [7:0]             dma_len,
    output logic                   dma_busy,
    output logic                   dma_done
);

    logic            ram_en, ram_we;
    kcpu_pkg::addr_t ram_addr;
    kcpu_pkg::byte_t ram_wdata, ram_rdata;

    kcpu_mem_if cpu_bus (.clk(clk), .rst(rst));
    kcpu_mem_if dma_bus (.clk(clk), .rst(rst));

    kcpu_memctrl u_memctrl (
        .clk(clk), .rst(rst),
        .pc(pc), .regs_x(regs_x), .regs_y(regs_y),
        .idx_addr(idx_addr), .stack_ptr(stack_ptr), .store_data(store_data),
        .cmd_start(cmd_start), .cmd(cmd), .sel(sel), .intvec(intvec),
        .busy(busy), .done(done), .is_op(is_op), .result(result),
        .mem(cpu_bus.requester)
    );

    kcpu_dma u_dma (
        .clk(clk), .rst(rst),
        .dma_start(dma_start), .dma_src(dma_src), .dma_dst(dma_dst), .dma_len(dma_len),
        .dma_busy(dma_busy), .dma_done(dma_done),
        .mem(dma_bus.requester)
    );

    kcpu_mem_arb u_mem_arb (
        .clk(clk), .rst(rst),
        .cpu(cpu_bus.arbiter), .dma(dma_bus.arbiter),
        .ram_en(ram_en), .ram_we(ram_we), .ram_addr(ram_addr),
        .ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
    );

    kcpu_ram u_ram (
        .clk(clk),
        .ram_en(ram_en), .ram_we(ram_we), .ram_addr(ram_addr),
        .ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
    );

endmodule

// ==== test/tb_kcpu_memsys.sv ====
////////////////////////////////////////////////////////////
// testbench for the kcpu memory subsystem
// drives cpu commands and a dma copy through the top level,
// keeps its own byte model of the ram and checks every
// done and dma_done with concurrent assertions
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_kcpu_memsys;

    localparam int MAX_CYCLES = 4000;  // ~100 commands at ~10 cycles plus a 32 byte copy

    logic                  clk, rst;
    kcpu_pkg::addr_t       pc, regs_x, regs_y, idx_addr, stack_ptr;
    logic [15:0]           store_data;
    logic                  cmd_start;
    kcpu_pkg::mem_cmd_e    cmd;
    kcpu_pkg::addr_sel_e   sel;
    logic [3:0]            intvec;
    logic                  busy, done, is_op;
    kcpu_pkg::fetch_word_u result;
    logic                  dma_start;
    kcpu_pkg::addr_t       dma_src, dma_dst;
    logic [7:0]            dma_len;
    logic                  dma_busy, dma_done;

    logic [7:0]  model [65536];          // reference copy of the ram
    logic [15:0] vec_tab [4] = '{16'hFFF8, 16'hFFF6, 16'hFFFC, 16'hFFFE};  // irq firq nmi rst
    logic [15:0] exp_word;
    logic        exp_rd, exp_is_op;
    logic        started, dma_armed, dma_seen;
    int          errors, n_cmds, cycles;

    kcpu_memsys u_kcpu_memsys (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // command result must match the model on every read
    a_result: assert property (@(posedge clk) disable iff (rst)
        (done && exp_rd) |-> result.word == exp_word)
        else begin
            errors++;
            $display("CHECK FAILED t=%0t result.word exp=%h got=%h",
                     $time, exp_word, $sampled(result.word));
        end

    a_is_op: assert property (@(posedge clk) disable iff (rst) done |-> is_op == exp_is_op)
        else begin
            errors++;
            $display("CHECK FAILED t=%0t is_op exp=%b got=%b", $time, exp_is_op, $sampled(is_op));
        end

    a_is_op_pulse: assert property (@(posedge clk) disable iff (rst) !done |-> !is_op)
        else begin
            errors++;
            $display("is_op went high at %0t without a done pulse", $time);
        end

    // nothing moves before the first command
    a_idle: assert property (@(posedge clk) disable iff (rst)
        !started |-> !(busy || done || is_op || dma_busy || dma_done))
        else begin
            errors++;
            $display("outputs active at %0t before any command was issued", $time);
        end

    a_dma_done: assert property (@(posedge clk) disable iff (rst)
        dma_done |-> dma_armed && !dma_busy)
        else begin
            errors++;
            $display("dma_done at %0t without a running copy or with dma_busy still high", $time);
        end

    always @(negedge clk) if (dma_done) dma_seen = 1'b1;

    always @(posedge clk) begin
        cycles++;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    // address the controller should use, straight from the command rules
    function automatic logic [15:0] base_addr(input kcpu_pkg::mem_cmd_e c,
                                              input kcpu_pkg::addr_sel_e s,
                                              input logic [3:0] vec);
        if (c == kcpu_pkg::op_fetch || c == kcpu_pkg::opd_fetch) return pc;
        if (c == kcpu_pkg::vec_fetch) begin
            for (int i = 0; i < 4; i++) if (vec[i]) return vec_tab[i];
        end
        case (s)
            kcpu_pkg::sel_x:   return regs_x;
            kcpu_pkg::sel_y:   return regs_y;
            kcpu_pkg::sel_idx: return idx_addr;
            default: return (c == kcpu_pkg::store8 || c == kcpu_pkg::store16) ?
                            stack_ptr - 16'd1 : stack_ptr;  // push below, pull at sp
        endcase
    endfunction

    // starts at posedge+1, returns at posedge+1 after done
    task automatic run_cmd(input kcpu_pkg::mem_cmd_e c, input kcpu_pkg::addr_sel_e s,
                           input logic [3:0] vec, input logic [15:0] wd);
        logic [15:0] a;
        a         = base_addr(c, s, vec);
        exp_rd    = !(c == kcpu_pkg::store8 || c == kcpu_pkg::store16);
        exp_is_op = c == kcpu_pkg::op_fetch;
        case (c)
            kcpu_pkg::op_fetch: exp_word = {model[a], 8'h00};
            kcpu_pkg::load8:    exp_word = {8'h00, model[a]};
            kcpu_pkg::store8:   model[a] = wd[7:0];
            kcpu_pkg::store16: begin
                model[a]         = wd[15:8];  // high byte at the lower address
                model[a + 16'd1] = wd[7:0];
            end
            default: exp_word = {model[a], model[a + 16'd1]};
        endcase
        started    = 1'b1;
        cmd        = c;
        sel        = s;
        intvec     = vec;
        store_data = wd;
        cmd_start  = 1'b1;
        @(posedge clk);
        #1 cmd_start = 1'b0;
        do @(negedge clk); while (!done);
        n_cmds++;
        @(posedge clk);
        #1;
    endtask

    task automatic store_load_sel(input kcpu_pkg::addr_sel_e s);
        logic [15:0] w;
        w = 16'($urandom);
        run_cmd(kcpu_pkg::store16, s, 4'b0000, w);
        if (s == kcpu_pkg::sel_stack) stack_ptr = stack_ptr - 16'd1;  // sp now on the pushed word
        run_cmd(kcpu_pkg::load16, s, 4'b0000, 16'h0000);
        run_cmd(kcpu_pkg::load8, s, 4'b0000, 16'h0000);
    endtask

    initial begin
        void'($urandom(72732));
        rst = 1'b1;
        errors = 0;
        n_cmds = 0;
        cycles = 0;
        started = 1'b0;
        dma_armed = 1'b0;
        dma_seen = 1'b0;
        exp_word = 16'h0000;
        exp_rd = 1'b0;
        exp_is_op = 1'b0;
        pc = 16'h0A00 | (16'($urandom) & 16'h00FE);
        regs_x = 16'h0100 | (16'($urandom) & 16'h00FE);
        regs_y = 16'h0300 | (16'($urandom) & 16'h00FE);
        idx_addr = 16'h0500 | (16'($urandom) & 16'h00FE);
        stack_ptr = 16'h0800 | (16'($urandom) & 16'h00FE);
        store_data = 16'h0000;
        cmd_start = 1'b0;
        cmd = kcpu_pkg::op_fetch;
        sel = kcpu_pkg::sel_x;
        intvec = 4'b0000;
        dma_start = 1'b0;
        dma_src = 16'h1000;
        dma_dst = 16'h2000;
        dma_len = 8'd32;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        repeat (4) @(posedge clk);  // quiet window for the idle check
        #1;

        for (int s = 0; s < 4; s++) store_load_sel(kcpu_pkg::addr_sel_e'(s));

        // opcode and operand fetch at pc
        regs_x = pc;
        run_cmd(kcpu_pkg::store16, kcpu_pkg::sel_x, 4'b0000, 16'($urandom));
        run_cmd(kcpu_pkg::op_fetch, kcpu_pkg::sel_x, 4'b0000, 16'h0000);
        run_cmd(kcpu_pkg::opd_fetch, kcpu_pkg::sel_x, 4'b0000, 16'h0000);

        for (int i = 0; i < 4; i++) begin
            regs_x = vec_tab[i];
            run_cmd(kcpu_pkg::store16, kcpu_pkg::sel_x, 4'b0000, 16'($urandom));
        end
        for (int i = 0; i < 4; i++)
            run_cmd(kcpu_pkg::vec_fetch, kcpu_pkg::sel_x, 4'(1 << i), 16'h0000);

        // source block for the copy
        for (int i = 0; i < 16; i++) begin
            regs_x = dma_src + 16'(2 * i);
            run_cmd(kcpu_pkg::store16, kcpu_pkg::sel_x, 4'b0000, 16'($urandom));
        end
        dma_armed = 1'b1;
        dma_start = 1'b1;
        @(posedge clk);
        #1 dma_start = 1'b0;
        for (int i = 0; i < 12; i++) begin  // cpu traffic fights the copy for the ram
            regs_y = 16'h4000 | (16'($urandom) & 16'h0FFE);
            run_cmd(kcpu_pkg::store16, kcpu_pkg::sel_y, 4'b0000, 16'($urandom));
            run_cmd(kcpu_pkg::load16, kcpu_pkg::sel_y, 4'b0000, 16'h0000);
        end
        while (!dma_seen) begin
            @(posedge clk);
            #1;
        end
        for (int i = 0; i < 32; i++) model[dma_dst + 16'(i)] = model[dma_src + 16'(i)];
        for (int i = 0; i < 32; i++) begin
            regs_x = dma_dst + 16'(i);
            run_cmd(kcpu_pkg::load8, kcpu_pkg::sel_x, 4'b0000, 16'h0000);
        end

        repeat (2) @(posedge clk);
        $display("closing: %0d commands, 1 dma copy, %0d errors", n_cmds, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
src/kcpu_pkg.sv
src/kcpu_mem_if.sv
src/kcpu_ram.sv
src/kcpu_mem_arb.sv
src/kcpu_memctrl.sv
src/kcpu_dma.sv
src/kcpu_memsys.sv
test/tb_kcpu_memsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the kcpu memory system testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_kcpu_memsys -f filelist.f -o tb_kcpu_memsys
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_kcpu_memsys)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1
